// File: mips_decode.f
design/mips_decode_pkg.sv
design/mips_control_unit.sv
design/mips_register_file.sv
design/mips_hazard_unit.sv
design/mips_id_ex_reg.sv
design/mips_decode_stage.sv
testbench/tb_mips_decode_stage.sv

// File: Bender.yml
package:
  name: mips_decode

sources:
  - design/mips_decode_pkg.sv
  - design/mips_control_unit.sv
  - design/mips_register_file.sv
  - design/mips_hazard_unit.sv
  - design/mips_id_ex_reg.sv
  - design/mips_decode_stage.sv
  - target: test
    files:
      - testbench/tb_mips_decode_stage.sv

// File: testbench/tb_mips_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module tb_mips_decode_stage
    import mips_decode_pkg::*;
();

    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 4;
    localparam int DRIVE_DELAY  = 2;
    localparam int N_STEPS      = 1800;
    // Test length plus reset and slack
    localparam int WATCHDOG_NS  = (N_STEPS + 200) * CLK_PERIOD + 100;
    localparam logic [119:0] OPCODES = {OP_RTYPE, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_ADDI,
        OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU,
        OP_SB, OP_SH, OP_SW, OP_HALT};

    logic      i_clk         = 1'b0;
    logic      i_reset       = 1'b1;
    word_t     i_instruction = '0;
    word_t     i_pc4         = '0;
    logic      i_wb_we       = 1'b0;
    reg_addr_t i_wb_addr     = '0;
    word_t     i_wb_data     = '0;
    logic      i_flush       = 1'b0;
    id_ex_t    o_id_ex;
    logic      o_stall;

    integer seed        = 80;
    word_t  model_regs [32];
    id_ex_t exp_q       = '0;
    id_ex_t next_q      = '0;
    string  next_name   = "";
    logic   exp_stall   = 1'b0;
    int     stall_count = 0;
    int     flush_count = 0;

    mips_decode_stage UUT (.*);

    always #(CLK_PERIOD / 2) i_clk = ~i_clk;

    task automatic abort_run();
        $display("*** TEST FAILED ***");
        $fatal(1, "Run stopped at the first failure");
    endtask

    task automatic check_value(input string test, input string name,
                               input logic [$bits(id_ex_t)-1:0] expected,
                               input logic [$bits(id_ex_t)-1:0] actual);
        assert (expected === actual)
        else
        begin
            $display("Error: test %s, %s expected %0h actual %0h", test, name, expected, actual);
            abort_run();
        end
    endtask

    // Register read as decode sees it, writeback bypass included
    function automatic word_t bypassed_read(input reg_addr_t addr);
        return (addr == '0) ? '0
             : (i_wb_we && i_wb_addr == addr) ? i_wb_data : model_regs[addr];
    endfunction

    function automatic id_ex_t decode_reference(input word_t instr, input word_t pc4);
        id_ex_t     d;
        logic [5:0] op;
        logic       r_jump;
        logic       r_alu;
        logic       logic_imm;
        logic       is_imm;
        logic       is_load;
        logic       is_store;
        op        = instr[31:26];
        r_jump    = (op == OP_RTYPE) && (instr[5:0] == FN_JR || instr[5:0] == FN_JALR);
        r_alu     = (op == OP_RTYPE) && !r_jump;
        logic_imm = (op == OP_ANDI) || (op == OP_ORI) || (op == OP_XORI);
        is_imm    = logic_imm || (op == OP_ADDI) || (op == OP_SLTI) || (op == OP_LUI);
        is_load   = (op == OP_LB) || (op == OP_LH) || (op == OP_LW) || (op == OP_LBU)
                    || (op == OP_LHU);
        is_store  = (op == OP_SB) || (op == OP_SH) || (op == OP_SW);
        d.pc4              = pc4;
        d.pc8              = pc4 + 32'd4;
        d.instruction      = instr;
        d.reg_data1        = bypassed_read(instr[25:21]);
        d.reg_data2        = bypassed_read(instr[20:16]);
        d.ext_imm          = logic_imm ? {16'h0000, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
        d.jump_target      = {pc4[31:28], instr[25:0], 2'b00};
        {d.rs, d.rt, d.rd} = instr[25:11];
        d.ex.jump          = (op == OP_J) || (op == OP_JAL);
        d.ex.jal           = (op == OP_JAL);
        d.ex.alu_src       = is_imm || is_load || is_store;
        d.ex.alu_op        = is_imm ? 2'd3 : r_alu ? 2'd2
                           : (op == OP_BEQ || op == OP_BNE) ? 2'd1 : 2'd0;
        d.ex.reg_dst       = r_alu;
        d.mem.branch       = (op == OP_BEQ);
        d.mem.nbranch      = (op == OP_BNE);
        d.mem.mem_write    = is_store;
        d.mem.mem_read     = is_load;
        d.mem.store_size   = (op == OP_SW) ? SIZE_WORD : (op == OP_SH) ? SIZE_HALF
                           : (op == OP_SB) ? SIZE_BYTE : 2'd0;
        d.wb.mem_to_reg    = is_load;
        d.wb.reg_write     = r_alu || (op == OP_RTYPE && instr[5:0] == FN_JALR)
                             || (op == OP_JAL) || is_imm || is_load;
        d.wb.load_size     = (op == OP_LW) ? SIZE_WORD : (op == OP_LH || op == OP_LHU) ? SIZE_HALF
                           : (op == OP_LB || op == OP_LBU) ? SIZE_BYTE : 2'd0;
        d.wb.zero_extend   = (op == OP_LBU) || (op == OP_LHU);
        d.wb.lui           = (op == OP_LUI);
        d.wb.jalr          = r_jump;
        d.wb.halt          = (op == OP_HALT);
        return d;
    endfunction

    task automatic drive_and_predict();
        int    sel;
        word_t instr;
        // A stalled instruction stays on the inputs
        if (!exp_stall)
        begin
            sel   = {$random(seed)} % 24;
            instr = $random(seed);
            // Registers 0 to 7 only, so a load and its user collide often
            instr[25:16] = instr[25:16] & 10'h0e7;
            if (sel < 20)
                instr[31:26] = OPCODES[sel * 6 +: 6];
            if (instr[31:26] == OP_RTYPE && instr[10])
                instr[5:0] = instr[9] ? FN_JALR : FN_JR;
            i_instruction = instr;
            i_pc4         = {$random(seed)} & 32'hffff_fffc;
        end
        i_wb_we   = $random(seed);
        i_wb_addr = {$random(seed)} % 8;
        i_wb_data = $random(seed);
        i_flush   = ({$random(seed)} % 16) == 0;
        #1;
        exp_stall = exp_q.mem.mem_read && (exp_q.rt != '0)
                    && (exp_q.rt == i_instruction[25:21] || exp_q.rt == i_instruction[20:16]);
        check_value("load-use stall", "o_stall", exp_stall, o_stall);
        next_q    = (i_flush || exp_stall) ? '0 : decode_reference(i_instruction, i_pc4);
        next_name = i_flush ? "flush" : exp_stall ? "load-use bubble"
                  : $sformatf("decode of opcode %02h", i_instruction[31:26]);
        stall_count += exp_stall;
        flush_count += i_flush;
    endtask

    initial
    begin
        for (int i = 0; i < 32; i++)
            model_regs[i] = '0;
        repeat (RESET_CYCLES) @(posedge i_clk);
        #(DRIVE_DELAY);
        i_reset = 1'b0;
        check_value("after reset", "o_id_ex", '0, o_id_ex);
        check_value("after reset", "o_stall", 1'b0, o_stall);
        drive_and_predict();
        for (int step = 0; step < N_STEPS; step++)
        begin
            @(posedge i_clk);
            // Model follows the edge just taken
            if (i_wb_we && (i_wb_addr != '0))
                model_regs[i_wb_addr] = i_wb_data;
            exp_q = next_q;
            #(DRIVE_DELAY);
            check_value(next_name, "o_id_ex", exp_q, o_id_ex);
            drive_and_predict();
        end
        if (stall_count == 0 || flush_count == 0)
        begin
            $display("Random stimulus produced no load-use stall or no flush");
            abort_run();
        end
        else
        begin
            $display("%0d cycles, %0d stalls, %0d flushes", N_STEPS, stall_count, flush_count);
            $display("*** TEST PASSED ***");
            $finish;
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns, the run hung", WATCHDOG_NS);
        abort_run();
    end

endmodule

`default_nettype wire

// File: design/mips_decode_stage.sv
`timescale 1ns/10ps
`default_nettype none

module mips_decode_stage
    import mips_decode_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_reset,
    input  wire word_t     i_instruction,
    input  wire word_t     i_pc4,
    input  wire logic      i_wb_we,
    input  wire reg_addr_t i_wb_addr,
    input  wire word_t     i_wb_data,
    input  wire logic      i_flush,
    output id_ex_t         o_id_ex,
    output logic           o_stall
);

    logic [5:0]  opcode;
    logic [5:0]  funct;
    reg_addr_t   rs;
    reg_addr_t   rt;
    reg_addr_t   rd;
    logic [15:0] imm;
    logic [25:0] jump_index;

    ex_ctrl_t    ex_ctrl;
    mem_ctrl_t   mem_ctrl;
    wb_ctrl_t    wb_ctrl;
    logic        imm_zero_ext;
    word_t       rs_data;
    word_t       rt_data;
    word_t       ext_imm;
    id_ex_t      id_ex_next;

    // Instruction fields
    assign opcode     = i_instruction[31:26];
    assign rs         = i_instruction[25:21];
    assign rt         = i_instruction[20:16];
    assign rd         = i_instruction[15:11];
    assign funct      = i_instruction[5:0];
    assign imm        = i_instruction[15:0];
    assign jump_index = i_instruction[25:0];

    assign ext_imm = imm_zero_ext ? {16'b0, imm} : {{16{imm[15]}}, imm};

    mips_control_unit u_control (
        .i_opcode       (opcode),
        .i_funct        (funct),
        .o_ex           (ex_ctrl),
        .o_mem          (mem_ctrl),
        .o_wb           (wb_ctrl),
        .o_imm_zero_ext (imm_zero_ext)
    );

    mips_register_file u_regfile (
        .i_clk     (i_clk),
        .i_reset   (i_reset),
        .i_rs_addr (rs),
        .i_rt_addr (rt),
        .i_we      (i_wb_we),
        .i_wr_addr (i_wb_addr),
        .i_wr_data (i_wb_data),
        .o_rs_data (rs_data),
        .o_rt_data (rt_data)
    );

    // Hazard check against the instruction now in EX
    mips_hazard_unit u_hazard (
        .i_rs          (rs),
        .i_rt          (rt),
        .i_ex_rt       (o_id_ex.rt),
        .i_ex_mem_read (o_id_ex.mem.mem_read),
        .o_stall       (o_stall)
    );

    always_comb
    begin
        id_ex_next             = '0;
        id_ex_next.pc4         = i_pc4;
        id_ex_next.pc8         = i_pc4 + 32'd4;
        id_ex_next.instruction = i_instruction;
        id_ex_next.reg_data1   = rs_data;
        id_ex_next.reg_data2   = rt_data;
        id_ex_next.ext_imm     = ext_imm;
        // Region of the delay slot PC, word aligned
        id_ex_next.jump_target = {i_pc4[31:28], jump_index, 2'b00};
        id_ex_next.rs          = rs;
        id_ex_next.rt          = rt;
        id_ex_next.rd          = rd;
        id_ex_next.ex          = ex_ctrl;
        id_ex_next.mem         = mem_ctrl;
        id_ex_next.wb          = wb_ctrl;
    end

    mips_id_ex_reg u_id_ex (
        .i_clk    (i_clk),
        .i_reset  (i_reset),
        .i_flush  (i_flush),
        .i_bubble (o_stall),
        .i_d      (id_ex_next),
        .o_q      (o_id_ex)
    );

endmodule

`default_nettype wire

// File: design/mips_id_ex_reg.sv
`timescale 1ns/10ps
`default_nettype none

module mips_id_ex_reg
    import mips_decode_pkg::*;
(
    input  wire logic   i_clk,
    input  wire logic   i_reset,
    input  wire logic   i_flush,
    input  wire logic   i_bubble,
    input  wire id_ex_t i_d,
    output id_ex_t      o_q
);

    logic clear;

    // Flush and load-use bubble both insert a NOP
    assign clear = i_flush || i_bubble;

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            o_q <= '0;
        end
        else if (clear)
        begin
            o_q <= '0;
        end
        else
        begin
            o_q <= i_d;
        end
    end

    // Squashed slot must not change architectural state
    flush_kills_writes: assert property (@(posedge i_clk) disable iff (i_reset)
        i_flush |=> (!o_q.wb.reg_write && !o_q.mem.mem_write));

endmodule

`default_nettype wire

// File: design/mips_hazard_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mips_hazard_unit
    import mips_decode_pkg::*;
(
    input  wire reg_addr_t i_rs,
    input  wire reg_addr_t i_rt,
    input  wire reg_addr_t i_ex_rt,
    input  wire logic      i_ex_mem_read,
    output logic           o_stall
);

    logic ex_loads_reg;
    logic rs_match;
    logic rt_match;

    // Load in EX targeting a real register
    assign ex_loads_reg = i_ex_mem_read && (i_ex_rt != '0);

    assign rs_match = (i_ex_rt == i_rs);
    assign rt_match = (i_ex_rt == i_rt);

    // Data not ready until after MEM, hold decode one cycle
    assign o_stall = ex_loads_reg && (rs_match || rt_match);

endmodule

`default_nettype wire

// File: design/mips_register_file.sv
`timescale 1ns/10ps
`default_nettype none

module mips_register_file
    import mips_decode_pkg::*;
(
    input  wire logic      i_clk,
    input  wire logic      i_reset,
    input  wire reg_addr_t i_rs_addr,
    input  wire reg_addr_t i_rt_addr,
    input  wire logic      i_we,
    input  wire reg_addr_t i_wr_addr,
    input  wire word_t     i_wr_data,
    output word_t          o_rs_data,
    output word_t          o_rt_data
);

    word_t regs [32];
    logic  wr_valid;

    // Register zero is never written
    assign wr_valid = i_we && (i_wr_addr != '0);

    always_ff @(posedge i_clk or posedge i_reset)
    begin
        if (i_reset)
        begin
            for (int i = 0; i < 32; i++)
                regs[i] <= '0;
        end
        else if (wr_valid)
        begin
            regs[i_wr_addr] <= i_wr_data;
        end
    end

    // Same-cycle writeback is visible to decode
    always_comb
    begin
        if (wr_valid && (i_wr_addr == i_rs_addr))
            o_rs_data = i_wr_data;
        else
            o_rs_data = regs[i_rs_addr];

        if (wr_valid && (i_wr_addr == i_rt_addr))
            o_rt_data = i_wr_data;
        else
            o_rt_data = regs[i_rt_addr];
    end

    zero_reg_reads_zero: assert property (@(posedge i_clk) disable iff (i_reset)
        ((i_rs_addr == '0) |-> (o_rs_data == '0)) and
        ((i_rt_addr == '0) |-> (o_rt_data == '0)));

endmodule

`default_nettype wire

// File: design/mips_control_unit.sv
`timescale 1ns/10ps
`default_nettype none

module mips_control_unit
    import mips_decode_pkg::*;
(
    input  wire logic [5:0] i_opcode,
    input  wire logic [5:0] i_funct,
    output ex_ctrl_t        o_ex,
    output mem_ctrl_t       o_mem,
    output wb_ctrl_t        o_wb,
    output logic            o_imm_zero_ext
);

    always_comb
    begin
        o_ex           = '0;
        o_mem          = '0;
        o_wb           = '0;
        o_imm_zero_ext = 1'b0;

        case (i_opcode)
            OP_RTYPE:
            begin
                if (i_funct == FN_JR)
                begin
                    o_wb.jalr = 1'b1;
                end
                else if (i_funct == FN_JALR)
                begin
                    o_wb.jalr      = 1'b1;
                    o_wb.reg_write = 1'b1;
                end
                else
                begin
                    o_ex.alu_op    = ALU_OP_RTYPE;
                    o_ex.reg_dst   = 1'b1;
                    o_wb.reg_write = 1'b1;
                end
            end
            OP_J:
            begin
                o_ex.jump = 1'b1;
            end
            OP_JAL:
            begin
                // Link into r31 is handled downstream
                o_ex.jump      = 1'b1;
                o_ex.jal       = 1'b1;
                o_wb.reg_write = 1'b1;
            end
            OP_BEQ, OP_BNE:
            begin
                o_ex.alu_op   = ALU_OP_BRANCH;
                o_mem.branch  = (i_opcode == OP_BEQ);
                o_mem.nbranch = (i_opcode == OP_BNE);
            end
            OP_ADDI, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
            begin
                o_ex.alu_src   = 1'b1;
                o_ex.alu_op    = ALU_OP_IMM;
                o_wb.reg_write = 1'b1;
                o_wb.lui       = (i_opcode == OP_LUI);
                // Logical immediates take the unsigned form
                o_imm_zero_ext = (i_opcode == OP_ANDI) || (i_opcode == OP_ORI)
                                 || (i_opcode == OP_XORI);
            end
            OP_LB, OP_LH, OP_LW, OP_LBU, OP_LHU:
            begin
                o_ex.alu_src    = 1'b1;
                o_ex.alu_op     = ALU_OP_MEM;
                o_mem.mem_read  = 1'b1;
                o_wb.mem_to_reg = 1'b1;
                o_wb.reg_write  = 1'b1;
                o_wb.zero_extend = (i_opcode == OP_LBU) || (i_opcode == OP_LHU);
                if (i_opcode == OP_LB || i_opcode == OP_LBU)
                    o_wb.load_size = SIZE_BYTE;
                else if (i_opcode == OP_LH || i_opcode == OP_LHU)
                    o_wb.load_size = SIZE_HALF;
                else
                    o_wb.load_size = SIZE_WORD;
            end
            OP_SB, OP_SH, OP_SW:
            begin
                o_ex.alu_src    = 1'b1;
                o_ex.alu_op     = ALU_OP_MEM;
                o_mem.mem_write = 1'b1;
                if (i_opcode == OP_SB)
                    o_mem.store_size = SIZE_BYTE;
                else if (i_opcode == OP_SH)
                    o_mem.store_size = SIZE_HALF;
                else
                    o_mem.store_size = SIZE_WORD;
            end
            OP_HALT:
            begin
                o_wb.halt = 1'b1;
            end
            default:
            begin
                // unknown opcode leaves everything at zero
            end
        endcase
    end

    // A single access per instruction reaches data memory
    mem_rw_excl: assert final (!(o_mem.mem_read && o_mem.mem_write));

endmodule

`default_nettype wire

// File: design/mips_decode_pkg.sv
`default_nettype none

package mips_decode_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;

    // Primary opcodes, instruction bits 31:26
    localparam logic [5:0] OP_RTYPE = 6'b000000;
    localparam logic [5:0] OP_J     = 6'b000010;
    localparam logic [5:0] OP_JAL   = 6'b000011;
    localparam logic [5:0] OP_BEQ   = 6'b000100;
    localparam logic [5:0] OP_BNE   = 6'b000101;
    localparam logic [5:0] OP_ADDI  = 6'b001000;
    localparam logic [5:0] OP_SLTI  = 6'b001010;
    localparam logic [5:0] OP_ANDI  = 6'b001100;
    localparam logic [5:0] OP_ORI   = 6'b001101;
    localparam logic [5:0] OP_XORI  = 6'b001110;
    localparam logic [5:0] OP_LUI   = 6'b001111;
    localparam logic [5:0] OP_LB    = 6'b100000;
    localparam logic [5:0] OP_LH    = 6'b100001;
    localparam logic [5:0] OP_LW    = 6'b100011;
    localparam logic [5:0] OP_LBU   = 6'b100100;
    localparam logic [5:0] OP_LHU   = 6'b100101;
    localparam logic [5:0] OP_SB    = 6'b101000;
    localparam logic [5:0] OP_SH    = 6'b101001;
    localparam logic [5:0] OP_SW    = 6'b101011;
    localparam logic [5:0] OP_HALT  = 6'b111111;

    // Function field of R-type register jumps
    localparam logic [5:0] FN_JR    = 6'b001000;
    localparam logic [5:0] FN_JALR  = 6'b001001;

    // ALU op groups seen by the execute stage
    localparam logic [1:0] ALU_OP_MEM    = 2'd0;
    localparam logic [1:0] ALU_OP_BRANCH = 2'd1;
    localparam logic [1:0] ALU_OP_RTYPE  = 2'd2;
    localparam logic [1:0] ALU_OP_IMM    = 2'd3;

    // Access sizes, zero means no access
    localparam logic [1:0] SIZE_BYTE = 2'd1;
    localparam logic [1:0] SIZE_HALF = 2'd2;
    localparam logic [1:0] SIZE_WORD = 2'd3;

    typedef struct packed {
        logic       jump;
        logic       jal;
        logic       alu_src;
        logic [1:0] alu_op;
        logic       reg_dst;
    } ex_ctrl_t;

    typedef struct packed {
        logic       branch;
        logic       nbranch;
        logic       mem_write;
        logic       mem_read;
        logic [1:0] store_size;
    } mem_ctrl_t;

    typedef struct packed {
        logic       mem_to_reg;
        logic       reg_write;
        logic [1:0] load_size;
        logic       zero_extend;
        logic       lui;
        logic       jalr;
        logic       halt;
    } wb_ctrl_t;

    typedef struct packed {
        word_t      pc4;
        word_t      pc8;
        word_t      instruction;
        word_t      reg_data1;
        word_t      reg_data2;
        word_t      ext_imm;
        word_t      jump_target;
        reg_addr_t  rs;
        reg_addr_t  rt;
        reg_addr_t  rd;
        ex_ctrl_t   ex;
        mem_ctrl_t  mem;
        wb_ctrl_t   wb;
    } id_ex_t;

endpackage

`default_nettype wire
